//--- src/cpu_isa_pkg.sv
package cpu_isa_pkg;

  typedef logic [31:0] word_t;      // data or byte address
  typedef logic [4:0]  reg_addr_t;  // x0..x31
  typedef logic [2:0]  funct3_t;

  // major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_e;

  // branch conditions
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store sizes
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  localparam funct3_t f3_sr = 3'b101;  // srl / sra, bit 30 picks arithmetic

  localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // low three bits follow funct3, bit 3 is instr[30]
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_sra    = 4'b1101,
    alu_pass_b = 4'b1111   // lui
  } alu_op_e;

  // execute result select
  typedef enum logic [1:0] {
    res_alu    = 2'd0,
    res_link   = 2'd1,  // pc + 4 for jal / jalr
    res_pc_imm = 2'd2   // auipc
  } res_sel_e;

  typedef logic [2:0] mem_size_t;  // funct3 of the load or store

endpackage

//--- src/instruction_fetch_unit.sv
`timescale 1ns/1ns

module instruction_fetch_unit import cpu_isa_pkg::*;
#(
  parameter int IMEM_DEPTH = 256
)
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  stall,
  input  logic  redirect,
  input  word_t redirect_pc,
  input  logic  prog_we,
  input  word_t prog_addr,   // byte address
  input  word_t prog_data,
  output word_t if_pc,
  output word_t if_instr,
  output word_t pc,
  output word_t debug_ins
);

  localparam int IW = $clog2(IMEM_DEPTH);

  word_t imem [IMEM_DEPTH];

  // program load port, only while the core is held in reset
  always_ff @(posedge clk)
  begin
    if (!rst_n && prog_we)
      imem[prog_addr[IW+1:2]] <= prog_data;
  end

  assign debug_ins = imem[pc[IW+1:2]];  // instruction at the current pc

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pc <= '0;
    else if (redirect)
      pc <= redirect_pc;  // taken branch or jump from execute
    else if (!stall)
      pc <= pc + 32'd4;
  end

  // IF/ID register
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      if_pc    <= '0;
      if_instr <= nop_instr;
    end
    else if (redirect)
      if_instr <= nop_instr;  // squash wrong-path fetch
    else if (!stall)
    begin
      if_pc    <= pc;
      if_instr <= debug_ins;
    end
  end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  logic      we,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [1:31];  // x0 is not stored

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && wr_addr != '0)
      regs[wr_addr] <= wr_data;
  end

  // write-through so decode sees the value retiring this cycle
  assign rs1_data = (rs1_addr == '0)                  ? '0 :
                    (we && wr_addr == rs1_addr)       ? wr_data :
                                                        regs[rs1_addr];

  assign rs2_data = (rs2_addr == '0)                  ? '0 :
                    (we && wr_addr == rs2_addr)       ? wr_data :
                                                        regs[rs2_addr];

endmodule

//--- src/instruction_decode_unit.sv
`timescale 1ns/1ns

module instruction_decode_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     if_pc,
  input  word_t     if_instr,
  input  logic      redirect,
  input  logic      mem_rd_valid,
  input  reg_addr_t mem_rd_addr,
  input  logic      mem_rd_is_load,
  input  word_t     mem_result,
  input  word_t     mem_load_data,
  output logic      stall,
  output word_t     id_pc,
  output word_t     id_rs1_data,
  output word_t     id_rs2_data,
  output word_t     id_imm,
  output reg_addr_t id_rs1,
  output reg_addr_t id_rs2,
  output reg_addr_t id_rd,
  output alu_op_e   id_alu_op,
  output res_sel_e  id_res_sel,
  output logic      id_src_b_imm,
  output logic      id_src_a_pc,
  output logic      id_branch,
  output logic      id_jump,
  output logic      id_jalr,
  output funct3_t   id_funct3,
  output logic      id_mem_rd,
  output logic      id_mem_wr,
  output logic      id_reg_we,
  output reg_addr_t ex_is_load_rd,
  output logic      wb_en,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  opcode_e   opcode;
  funct3_t   f3;
  reg_addr_t rs1, rs2, rd;
  word_t     rs1_val, rs2_val, imm;
  alu_op_e   alu_op;
  res_sel_e  res_sel;
  logic      src_b_imm, src_a_pc, branch, jump, jalr, mem_rd, mem_wr, reg_we;

  assign opcode = opcode_e'(if_instr[6:0]);
  assign f3     = if_instr[14:12];
  assign rd     = if_instr[11:7];
  assign rs1    = if_instr[19:15];
  assign rs2    = if_instr[24:20];

  // write-back select, also the trace
  assign wb_en   = mem_rd_valid;
  assign wb_addr = mem_rd_addr;
  assign wb_data = mem_rd_is_load ? mem_load_data : mem_result;

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n),
    .rs1_addr(rs1), .rs2_addr(rs2),
    .we(wb_en), .wr_addr(wb_addr), .wr_data(wb_data),
    .rs1_data(rs1_val), .rs2_data(rs2_val)
  );

  always_comb
  begin
    alu_op    = alu_add;
    res_sel   = res_alu;
    src_b_imm = 1'b1;
    src_a_pc  = 1'b0;
    {branch, jump, jalr, mem_rd, mem_wr, reg_we} = '0;
    imm = {{20{if_instr[31]}}, if_instr[31:20]};  // I format
    case (opcode)
      opc_op:
      begin
        alu_op    = alu_op_e'({if_instr[30], f3});
        src_b_imm = 1'b0;
        reg_we    = 1'b1;
      end
      opc_op_imm:
      begin
        alu_op = alu_op_e'({if_instr[30] && f3 == f3_sr, f3});  // only srai uses bit 30
        reg_we = 1'b1;
      end
      opc_load:
      begin
        mem_rd = 1'b1;
        reg_we = 1'b1;
      end
      opc_store:
      begin
        mem_wr = 1'b1;
        imm    = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
      end
      opc_branch:
      begin
        branch    = 1'b1;
        src_a_pc  = 1'b1;
        src_b_imm = 1'b0;  // compare rs1 with rs2
        imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
               if_instr[11:8], 1'b0};
      end
      opc_jal:
      begin
        jump     = 1'b1;
        src_a_pc = 1'b1;
        res_sel  = res_link;
        reg_we   = 1'b1;
        imm = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
               if_instr[30:21], 1'b0};
      end
      opc_jalr:
      begin
        jump    = 1'b1;
        jalr    = 1'b1;
        res_sel = res_link;
        reg_we  = 1'b1;
      end
      opc_lui:
      begin
        alu_op = alu_pass_b;
        reg_we = 1'b1;
        imm    = {if_instr[31:12], 12'b0};
      end
      opc_auipc:
      begin
        src_a_pc = 1'b1;
        res_sel  = res_pc_imm;
        reg_we   = 1'b1;
        imm      = {if_instr[31:12], 12'b0};
      end
      default: ;
    endcase
    if (rd == '0)
      reg_we = 1'b0;  // x0 writes dropped here
  end

  // load in execute feeding the instruction in decode
  assign ex_is_load_rd = (id_mem_rd && id_reg_we) ? id_rd : '0;
  assign stall = (ex_is_load_rd != '0) && (ex_is_load_rd == rs1 || ex_is_load_rd == rs2);

  // ID/EX control, bubble on stall or flush
  always_ff @(posedge clk)
  begin
    if (!rst_n || stall || redirect)
      {id_branch, id_jump, id_mem_rd, id_mem_wr, id_reg_we} <= '0;
    else
      {id_branch, id_jump, id_mem_rd, id_mem_wr, id_reg_we} <=
        {branch, jump, mem_rd, mem_wr, reg_we};
  end

  // ID/EX payload
  always_ff @(posedge clk)
  begin
    id_pc        <= if_pc;
    id_rs1_data  <= rs1_val;
    id_rs2_data  <= rs2_val;
    id_imm       <= imm;
    id_rs1       <= rs1;
    id_rs2       <= rs2;
    id_rd        <= rd;
    id_alu_op    <= alu_op;
    id_res_sel   <= res_sel;
    id_src_b_imm <= src_b_imm;
    id_src_a_pc  <= src_a_pc;
    id_jalr      <= jalr;
    id_funct3    <= f3;
  end

endmodule

//--- src/instruction_execute_unit.sv
`timescale 1ns/1ns

module instruction_execute_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     id_pc,
  input  word_t     id_rs1_data,
  input  word_t     id_rs2_data,
  input  word_t     id_imm,
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  reg_addr_t id_rd,
  input  alu_op_e   id_alu_op,
  input  res_sel_e  id_res_sel,
  input  logic      id_src_b_imm,
  input  logic      id_src_a_pc,
  input  logic      id_branch,
  input  logic      id_jump,
  input  logic      id_jalr,
  input  funct3_t   id_funct3,
  input  logic      id_mem_rd,
  input  logic      id_mem_wr,
  input  logic      id_reg_we,
  input  logic      mem_fwd_we,
  input  reg_addr_t mem_fwd_addr,
  input  word_t     mem_fwd_data,
  input  logic      wb_en,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output logic      redirect,
  output word_t     redirect_pc,
  output word_t     ex_result,
  output word_t     ex_store_data,
  output reg_addr_t ex_rd,
  output logic      ex_reg_we,
  output logic      ex_mem_rd,
  output logic      ex_mem_wr,
  output mem_size_t ex_size
);

  word_t op_a, op_b, alu_b, alu_out, target, result;
  logic  take;

  // youngest producer wins
  assign op_a = (mem_fwd_we && mem_fwd_addr == id_rs1) ? mem_fwd_data :
                (wb_en && wb_addr == id_rs1)           ? wb_data : id_rs1_data;
  assign op_b = (mem_fwd_we && mem_fwd_addr == id_rs2) ? mem_fwd_data :
                (wb_en && wb_addr == id_rs2)           ? wb_data : id_rs2_data;

  assign alu_b = id_src_b_imm ? id_imm : op_b;

  always_comb
  begin
    case (id_alu_op)
      alu_sub:    alu_out = op_a - alu_b;
      alu_sll:    alu_out = op_a << alu_b[4:0];
      alu_slt:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
      alu_sltu:   alu_out = {31'b0, op_a < alu_b};
      alu_xor:    alu_out = op_a ^ alu_b;
      alu_srl:    alu_out = op_a >> alu_b[4:0];
      alu_sra:    alu_out = $signed(op_a) >>> alu_b[4:0];
      alu_or:     alu_out = op_a | alu_b;
      alu_and:    alu_out = op_a & alu_b;
      alu_pass_b: alu_out = alu_b;
      default:    alu_out = op_a + alu_b;
    endcase
  end

  always_comb
  begin
    case (id_funct3)
      f3_beq:  take = op_a == op_b;
      f3_bne:  take = op_a != op_b;
      f3_blt:  take = $signed(op_a) < $signed(op_b);
      f3_bge:  take = $signed(op_a) >= $signed(op_b);
      f3_bltu: take = op_a < op_b;
      f3_bgeu: take = op_a >= op_b;
      default: take = 1'b0;
    endcase
  end

  assign target      = (id_src_a_pc ? id_pc : op_a) + id_imm;  // also the auipc result
  assign redirect    = id_jump || (id_branch && take);
  assign redirect_pc = id_jalr ? {target[31:1], 1'b0} : target;

  always_comb
  begin
    case (id_res_sel)
      res_link:   result = id_pc + 32'd4;
      res_pc_imm: result = target;
      default:    result = alu_out;
    endcase
  end

  // EX/MEM
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      {ex_reg_we, ex_mem_rd, ex_mem_wr} <= '0;
    else
      {ex_reg_we, ex_mem_rd, ex_mem_wr} <= {id_reg_we, id_mem_rd, id_mem_wr};
  end

  always_ff @(posedge clk)
  begin
    ex_result     <= result;
    ex_store_data <= op_b;
    ex_rd         <= id_rd;
    ex_size       <= id_funct3;
  end

endmodule

//--- src/memory_access_unit.sv
`timescale 1ns/1ns

module memory_access_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
  parameter int DMEM_DEPTH = 64
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  word_t     ex_result,      // address for loads and stores
  input  word_t     ex_store_data,
  input  reg_addr_t ex_rd,
  input  logic      ex_reg_we,
  input  logic      ex_mem_rd,
  input  logic      ex_mem_wr,
  input  mem_size_t ex_size,
  output logic      mem_fwd_we,
  output reg_addr_t mem_fwd_addr,
  output word_t     mem_fwd_data,
  output logic      mem_rd_valid,
  output reg_addr_t mem_rd_addr,
  output logic      mem_rd_is_load,
  output word_t     mem_result,
  output word_t     mem_load_data
);

  localparam int DW = $clog2(DMEM_DEPTH);

  word_t       dmem [DMEM_DEPTH];
  logic [1:0]  off;
  logic [3:0]  be;
  word_t       wdata, rdata, lane, load_val;

  assign off = ex_result[1:0];

  // loads are not ready until write-back
  assign mem_fwd_we   = ex_reg_we && !ex_mem_rd;
  assign mem_fwd_addr = ex_rd;
  assign mem_fwd_data = ex_result;

  always_comb
  begin
    case (ex_size)
      f3_byte: begin be = 4'b0001 << off;          wdata = {4{ex_store_data[7:0]}};  end
      f3_half: begin be = 4'b0011 << {off[1], 1'b0}; wdata = {2{ex_store_data[15:0]}}; end
      f3_word: begin be = 4'b1111;                 wdata = ex_store_data;            end
      default: begin be = 4'b0000;                 wdata = ex_store_data;            end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (ex_mem_wr)
      for (int i = 0; i < 4; i++)
        if (be[i])
          dmem[ex_result[DW+1:2]][i*8 +: 8] <= wdata[i*8 +: 8];
  end

  assign rdata = dmem[ex_result[DW+1:2]];
  assign lane  = rdata >> {off, 3'b000};  // addressed byte or half to bit 0

  always_comb
  begin
    case (ex_size)
      f3_byte:   load_val = {{24{lane[7]}}, lane[7:0]};
      f3_half:   load_val = {{16{lane[15]}}, lane[15:0]};
      f3_byte_u: load_val = {24'b0, lane[7:0]};
      f3_half_u: load_val = {16'b0, lane[15:0]};
      default:   load_val = rdata;
    endcase
  end

  // MEM/WB
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      mem_rd_valid <= 1'b0;
    else
      mem_rd_valid <= ex_reg_we;
  end

  always_ff @(posedge clk)
  begin
    mem_rd_addr    <= ex_rd;
    mem_rd_is_load <= ex_mem_rd;
    mem_result     <= ex_result;
    mem_load_data  <= load_val;
  end

endmodule

//--- src/cpu.sv
`timescale 1ns/1ns

module cpu import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 64
)
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      prog_we,
  input  word_t     prog_addr,
  input  word_t     prog_data,
  output word_t     pc,
  output word_t     debug_ins,
  output logic      wb_en,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  logic      stall, redirect;
  word_t     redirect_pc, if_pc, if_instr;
  word_t     id_pc, id_rs1_data, id_rs2_data, id_imm;
  reg_addr_t id_rs1, id_rs2, id_rd;
  alu_op_e   id_alu_op;
  res_sel_e  id_res_sel;
  funct3_t   id_funct3;
  logic      id_src_b_imm, id_src_a_pc, id_branch, id_jump, id_jalr;
  logic      id_mem_rd, id_mem_wr, id_reg_we;
  word_t     ex_result, ex_store_data;
  reg_addr_t ex_rd;
  logic      ex_reg_we, ex_mem_rd, ex_mem_wr;
  mem_size_t ex_size;
  logic      mem_fwd_we, mem_rd_valid, mem_rd_is_load;
  reg_addr_t mem_fwd_addr, mem_rd_addr;
  word_t     mem_fwd_data, mem_result, mem_load_data;

  instruction_fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) if_unit (
    .clk(clk), .rst_n(rst_n), .stall(stall),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .if_pc(if_pc), .if_instr(if_instr), .pc(pc), .debug_ins(debug_ins)
  );

  instruction_decode_unit id_unit (
    .clk(clk), .rst_n(rst_n), .if_pc(if_pc), .if_instr(if_instr), .redirect(redirect),
    .mem_rd_valid(mem_rd_valid), .mem_rd_addr(mem_rd_addr),
    .mem_rd_is_load(mem_rd_is_load), .mem_result(mem_result),
    .mem_load_data(mem_load_data), .stall(stall),
    .id_pc(id_pc), .id_rs1_data(id_rs1_data), .id_rs2_data(id_rs2_data), .id_imm(id_imm),
    .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd),
    .id_alu_op(id_alu_op), .id_res_sel(id_res_sel),
    .id_src_b_imm(id_src_b_imm), .id_src_a_pc(id_src_a_pc),
    .id_branch(id_branch), .id_jump(id_jump), .id_jalr(id_jalr), .id_funct3(id_funct3),
    .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr), .id_reg_we(id_reg_we),
    .ex_is_load_rd(), .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
  );

  instruction_execute_unit iex_unit (
    .clk(clk), .rst_n(rst_n),
    .id_pc(id_pc), .id_rs1_data(id_rs1_data), .id_rs2_data(id_rs2_data), .id_imm(id_imm),
    .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd),
    .id_alu_op(id_alu_op), .id_res_sel(id_res_sel),
    .id_src_b_imm(id_src_b_imm), .id_src_a_pc(id_src_a_pc),
    .id_branch(id_branch), .id_jump(id_jump), .id_jalr(id_jalr), .id_funct3(id_funct3),
    .id_mem_rd(id_mem_rd), .id_mem_wr(id_mem_wr), .id_reg_we(id_reg_we),
    .mem_fwd_we(mem_fwd_we), .mem_fwd_addr(mem_fwd_addr), .mem_fwd_data(mem_fwd_data),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_rd(ex_rd),
    .ex_reg_we(ex_reg_we), .ex_mem_rd(ex_mem_rd), .ex_mem_wr(ex_mem_wr), .ex_size(ex_size)
  );

  memory_access_unit #(.DMEM_DEPTH(DMEM_DEPTH)) mem_access_unit (
    .clk(clk), .rst_n(rst_n),
    .ex_result(ex_result), .ex_store_data(ex_store_data), .ex_rd(ex_rd),
    .ex_reg_we(ex_reg_we), .ex_mem_rd(ex_mem_rd), .ex_mem_wr(ex_mem_wr), .ex_size(ex_size),
    .mem_fwd_we(mem_fwd_we), .mem_fwd_addr(mem_fwd_addr), .mem_fwd_data(mem_fwd_data),
    .mem_rd_valid(mem_rd_valid), .mem_rd_addr(mem_rd_addr),
    .mem_rd_is_load(mem_rd_is_load), .mem_result(mem_result),
    .mem_load_data(mem_load_data)
  );

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_isa_pkg::*;
();

  localparam int imem_depth = 256;
  localparam int dmem_depth = 64;
  localparam int dmem_bytes = dmem_depth * 4;
  localparam int prog_len   = 200;
  localparam int max_cycles = prog_len * 3 + 100;  // at most 3 cycles per instruction

  logic      clk = 1'b0;
  logic      rst_n;
  logic      prog_we;
  word_t     prog_addr;
  word_t     prog_data;
  word_t     pc;
  word_t     debug_ins;
  logic      wb_en;
  reg_addr_t wb_addr;
  word_t     wb_data;

  int        seed = 64;
  int        cycles = 0;
  int        addr_errs = 0;
  int        data_errs = 0;
  int        pc_errs = 0;
  int        fetch_errs = 0;
  int        extra_errs = 0;
  int        missing = 0;
  logic      timed_out;

  word_t     prog [$];
  reg_addr_t exp_addr [$];  // expected register writes in program order
  word_t     exp_data [$];

  // reference model state
  word_t      mreg [32];
  logic [7:0] mmem [dmem_bytes];
  bit         mwritten [dmem_bytes];  // bytes stored so far on the executed path
  reg_addr_t  last_rd;

  cpu #(.IMEM_DEPTH(imem_depth), .DMEM_DEPTH(dmem_depth)) dut (
    .clk(clk), .rst_n(rst_n),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .pc(pc), .debug_ins(debug_ins),
    .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
  );

  always #5 clk = ~clk;

  function automatic int rnd(input int n);
    rnd = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // mostly x1..x7 so neighbours depend on each other
  function automatic reg_addr_t pick_reg();
    int r;
    r = rnd(10);
    if (r == 0)
      pick_reg = '0;
    else if (r < 8)
      pick_reg = reg_addr_t'(r);
    else
      pick_reg = reg_addr_t'(8 + rnd(24));
  endfunction

  function automatic word_t enc_r(input logic alt, input funct3_t f3,
                                  input reg_addr_t rd, rs1, rs2);
    enc_r = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                  input funct3_t f3, input reg_addr_t rd,
                                  input opcode_e opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2, rs1,
                                  input funct3_t f3);
    enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2, rs1,
                                  input funct3_t f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                  input opcode_e opc);
    enc_u = {imm, rd, opc};
  endfunction

  function automatic word_t alu_model(input funct3_t f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0:    alu_model = alt ? a - b : a + b;
      3'd1:    alu_model = a << b[4:0];
      3'd2:    alu_model = {31'b0, $signed(a) < $signed(b)};
      3'd3:    alu_model = {31'b0, a < b};
      3'd4:    alu_model = a ^ b;
      3'd5:
      begin
        if (alt)
          alu_model = $signed(a) >>> b[4:0];
        else
          alu_model = a >> b[4:0];
      end
      3'd6:    alu_model = a | b;
      default: alu_model = a & b;
    endcase
  endfunction

  // one instruction of the ISA model, skip is the number of instructions jumped over
  task automatic model_exec(input word_t ins, input word_t pc_now, output int skip);
    funct3_t   f3;
    reg_addr_t rd;
    word_t     a, b, imm_i, imm_s, imm_b, imm_j, val, tgt;
    int        ad;
    logic      wr, take;
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = mreg[ins[19:15]];
    b     = mreg[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    wr    = 1'b1;
    val   = '0;
    tgt   = pc_now + 32'd4;
    case (ins[6:0])
      opc_op:     val = alu_model(f3, ins[30], a, b);
      opc_op_imm: val = alu_model(f3, f3 == 3'd5 && ins[30], a, imm_i);
      opc_lui:    val = {ins[31:12], 12'b0};
      opc_auipc:  val = pc_now + {ins[31:12], 12'b0};
      opc_load:
      begin
        ad = int'(a + imm_i);
        case (f3)
          3'd0:    val = {{24{mmem[ad][7]}}, mmem[ad]};
          3'd1:    val = {{16{mmem[ad + 1][7]}}, mmem[ad + 1], mmem[ad]};
          3'd4:    val = {24'b0, mmem[ad]};
          3'd5:    val = {16'b0, mmem[ad + 1], mmem[ad]};
          default: val = {mmem[ad + 3], mmem[ad + 2], mmem[ad + 1], mmem[ad]};
        endcase
      end
      opc_store:
      begin
        wr = 1'b0;
        ad = int'(a + imm_s);
        for (int j = 0; j < (1 << f3); j++)
        begin
          mmem[ad + j]     = b[8*j +: 8];
          mwritten[ad + j] = 1'b1;
        end
      end
      opc_branch:
      begin
        wr = 1'b0;
        case (f3)
          3'd0:    take = a == b;
          3'd1:    take = a != b;
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          default: take = a >= b;
        endcase
        if (take)
          tgt = pc_now + imm_b;
      end
      opc_jal:
      begin
        val = pc_now + 32'd4;  // link
        tgt = pc_now + imm_j;
      end
      opc_jalr:
      begin
        val = pc_now + 32'd4;
        tgt = (a + imm_i) & ~32'd1;
      end
      default: wr = 1'b0;
    endcase
    skip = int'((tgt - pc_now) >> 2) - 1;
    if (wr && rd != '0)
    begin
      mreg[rd] = val;
      exp_addr.push_back(rd);
      exp_data.push_back(val);
    end
  endtask

  task automatic gen_instr(input int idx, output word_t ins);
    int          kind, k, n;
    reg_addr_t   rd, rs1, rs2;
    funct3_t     f3;
    word_t       tgt, off;
    logic [11:0] ad;
    logic        ok;
    kind = rnd(16);
    rd   = pick_reg();
    rs1  = (rnd(3) == 0) ? last_rd : pick_reg();  // back-to-back dependency
    rs2  = pick_reg();
    f3   = funct3_t'(rnd(8));
    k    = 1 + rnd(3);  // forward offset in instructions
    if (idx + k > prog_len)
      k = prog_len - idx;
    if (kind < 4)
      ins = enc_r((f3 == 3'd0 || f3 == 3'd5) && rnd(2) == 1, f3, rd, rs1, rs2);
    else if (kind < 7)
    begin
      if (f3 == 3'd1 || f3 == 3'd5)
        ins = enc_i({1'b0, f3 == 3'd5 && rnd(2) == 1, 5'b0, 5'(rnd(32))},
                    rs1, f3, rd, opc_op_imm);
      else
        ins = enc_i(12'(rnd(4096)), rs1, f3, rd, opc_op_imm);
    end
    else if (kind < 11)
    begin
      // loads only read bytes already stored, otherwise it becomes a store
      f3 = funct3_t'(rnd(3));
      n  = 1 << f3;
      ad = 12'(rnd(dmem_bytes) & ~(n - 1));
      ok = 1'b1;
      for (int j = 0; j < n; j++)
        ok = ok && mwritten[int'(ad) + j];
      if (kind < 9 && ok)
        ins = enc_i(ad, 5'd0, (f3 != 3'd2 && rnd(2) == 1) ? (f3 | 3'd4) : f3, rd, opc_load);
      else
        ins = enc_s(ad, rs2, 5'd0, f3);
    end
    else if (kind < 13)
    begin
      f3 = funct3_t'(rnd(6));
      if (f3 >= 3'd2)
        f3 = f3 + 3'd2;  // skip the two unused codes
      ins = enc_b(13'(k * 4), rs2, rs1, f3);
    end
    else if (kind == 13)
      ins = enc_j(21'(k * 4), rd);
    else if (kind == 14)
    begin
      tgt = word_t'((idx + k) * 4);
      off = tgt - mreg[rs1];
      if ($signed(off) < -2048 || $signed(off) > 2047)
      begin
        rs1 = '0;  // absolute target
        off = tgt;
      end
      ins = enc_i(off[11:0], rs1, 3'd0, rd, opc_jalr);
    end
    else if (rnd(2) == 1)
      ins = enc_u(20'($random(seed)), rd, opc_lui);
    else
      ins = enc_u(20'($random(seed)), rd, opc_auipc);
    last_rd = rd;
  endtask

  // generation and model run in lockstep so loads and jalr see known state
  task automatic build_program();
    int    skip;
    word_t ins;
    skip    = 0;
    last_rd = '0;
    for (int r = 0; r < 32; r++)
      mreg[r] = '0;
    for (int idx = 0; idx < prog_len; idx++)
    begin
      gen_instr(idx, ins);
      prog.push_back(ins);
      if (skip > 0)
        skip--;  // jumped over on the executed path
      else
        model_exec(ins, word_t'(idx * 4), skip);
    end
    prog.push_back(enc_j('0, '0));  // self-loop
  endtask

  // word loaded into instruction memory at a byte address
  function automatic word_t imem_word(input word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < prog.size())
      imem_word = prog[idx];
    else
      imem_word = nop_instr;
  endfunction

  task automatic check_wb_addr(input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
    begin
      addr_errs++;
      $display("ERR %0t: write-back to x%0d, expected x%0d", $time, got, exp);
    end
  endtask

  task automatic check_wb_data(input word_t got, input word_t exp);
    if (got !== exp)
    begin
      data_errs++;
      $display("ERR %0t: write-back data %h, expected %h", $time, got, exp);
    end
  endtask

  // forward-only jumps, so fetch never runs past the two words after the self-loop
  task automatic check_pc(input word_t got);
    if (got[1:0] != 2'b00 || got > word_t'((prog_len + 2) * 4))
    begin
      pc_errs++;
      $display("ERR %0t: pc %h outside the program", $time, got);
    end
  endtask

  task automatic check_fetch(input word_t got, input word_t exp);
    if (got !== exp)
    begin
      fetch_errs++;
      $display("ERR %0t: fetched %h, expected %h", $time, got, exp);
    end
  endtask

  always @(negedge clk)
  begin
    if (wb_en === 1'b1)
    begin
      if (exp_addr.size() == 0)
      begin
        extra_errs++;
        $display("%0t: extra register write to x%0d after the last expected one",
                 $time, wb_addr);
      end
      else
      begin
        check_wb_addr(wb_addr, exp_addr.pop_front());
        check_wb_data(wb_data, exp_data.pop_front());
      end
    end
  end

  initial
  begin
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    build_program();
    for (int i = 0; i < imem_depth; i++)
    begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = word_t'(i * 4);
      prog_data = (i < prog.size()) ? prog[i] : nop_instr;  // pad with nops
    end
    @(negedge clk);
    prog_we = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    while ((exp_addr.size() != 0 || pc != word_t'(prog_len * 4)) && cycles < max_cycles)
    begin
      @(negedge clk);
      cycles++;
      check_pc(pc);
      check_fetch(debug_ins, imem_word(pc));
    end
    timed_out = cycles >= max_cycles;
    repeat (8) @(posedge clk);  // drain, catches stray writes
    missing = exp_addr.size();
    if (timed_out)
      $display("timeout after %0d cycles, %0d expected register writes never arrived",
               cycles, missing);
    $display("errors: addr %0d, data %0d, pc %0d, fetch %0d, extra %0d, missing %0d",
             addr_errs, data_errs, pc_errs, fetch_errs, extra_errs, missing);
    if (!timed_out && addr_errs + data_errs + pc_errs + fetch_errs + extra_errs + missing == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tb.f
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/instruction_fetch_unit.sv
src/reg_file.sv
src/instruction_decode_unit.sv
src/instruction_execute_unit.sv
src/memory_access_unit.sv
src/cpu.sv
testbench/cpu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TB_TOP     ?= cpu_tb
RTL_TOP    ?= cpu
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_TEXT  ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
